//--- hdl/hpsdr_pkg.sv
// Widths, typedefs, unpacker state encoding and protocol constants for the downstream path
package hpsdr_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_t;
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_word_t;
  // I in the upper half, Q in the lower half
  typedef logic [31:0] iq_sample_t;
  typedef logic [3:0]  seq_t;

  typedef enum logic [4:0] {
    ST_START, ST_PREAMBLE, ST_DECODE, ST_RUNSTOP, ST_DISCOVERY, ST_ENDPOINT,
    ST_SEQ3, ST_SEQ2, ST_SEQ1, ST_SEQ0,
    ST_SYNC2, ST_SYNC1, ST_SYNC0,
    ST_CMDCTRL, ST_CMDDATA3, ST_CMDDATA2, ST_CMDDATA1, ST_CMDDATA0,
    ST_PUSHI1, ST_PUSHI0, ST_PUSHQ1, ST_PUSHQ0
  } ds_state_t;

  // Ports 1024 and 1025 share this upper part
  localparam logic [14:0] BASE_PORT_HI = 15'd512;

  localparam byte_t SYNC_BYTE     = 8'h7f;
  localparam byte_t PREAMBLE_BYTE = 8'hfe;

  // Packet type codes
  localparam byte_t PKT_DATA     = 8'h01;
  localparam byte_t PKT_DISCOVER = 8'h02;
  localparam byte_t PKT_RUNSTOP  = 8'h04;
  localparam byte_t PKT_CMDONLY  = 8'h05;

endpackage

//--- hdl/ds_unpack.sv
// Downstream byte-level protocol FSM with sequence check and I/Q sample assembly
`timescale 1ns/1ps

module ds_unpack import hpsdr_pkg::*; #(
  parameter int FRAME_SAMPLES = 63
) (
  input  logic       clk,
  input  logic       rst,
  input  port_t      eth_port,
  input  logic       eth_broadcast,
  input  logic       eth_valid,
  input  byte_t      eth_data,
  input  logic       eth_unreachable,
  input  logic       abort,
  output logic       cmd_we,
  output cmd_addr_t  cmd_addr,
  output cmd_word_t  cmd_data,
  output logic       cmd_resprqst,
  output logic       ptt,
  output logic       runstop_we,
  output byte_t      runstop_byte,
  output logic       pkt_seen,
  output logic       ds_pkt_cnt,
  output logic       discover_cnt,
  output logic       discover_port,
  output logic       sample_we,
  output iq_sample_t sample_in
);

  localparam int CNT_W = $clog2(FRAME_SAMPLES + 1);

  ds_state_t        state;
  seq_t             seq_ref;
  seq_t             seq_diff;
  logic             relax;
  logic             push_en;
  logic             cmd_only;
  logic             frame_cnt;
  logic [CNT_W-1:0] sample_cnt;
  logic [23:0]      iq_hold;

  // Distance from the last accepted packet, 1..7 counts as in order
  assign seq_diff = eth_data[3:0] - seq_ref;

  // Data packet start clears the watchdog
  assign pkt_seen = eth_valid && (state == ST_SEQ1);

  always_ff @(posedge clk) begin
    cmd_we     <= 1'b0;
    runstop_we <= 1'b0;
    sample_we  <= 1'b0;
    if (rst) begin
      state         <= ST_START;
      ptt           <= 1'b0;
      seq_ref       <= '1;
      relax         <= 1'b0;
      push_en       <= 1'b0;
      cmd_only      <= 1'b0;
      frame_cnt     <= 1'b0;
      sample_cnt    <= '0;
      ds_pkt_cnt    <= 1'b0;
      discover_cnt  <= 1'b0;
      discover_port <= 1'b0;
    end else if (abort || eth_unreachable) begin
      state <= ST_START;
      ptt   <= 1'b0;
    end else if (!eth_valid) begin
      state <= ST_START;
    end else begin
      state <= ST_START;
      case (state)
        ST_START: begin
          if (eth_data[7:4] == 4'he && eth_port[15:1] == BASE_PORT_HI) begin
            relax <= eth_data[1];
            state <= ST_PREAMBLE;
          end
        end
        ST_PREAMBLE: begin
          if (eth_data == PREAMBLE_BYTE) state <= ST_DECODE;
        end
        ST_DECODE: begin
          cmd_only <= 1'b0;
          if (eth_data == PKT_DATA) begin
            state <= ST_ENDPOINT;
          end else if (eth_data == PKT_RUNSTOP) begin
            state <= ST_RUNSTOP;
          end else if (eth_data == PKT_DISCOVER) begin
            discover_cnt  <= ~discover_cnt;
            discover_port <= eth_port[0];
            state         <= ST_DISCOVERY;
          end else if (eth_data == PKT_CMDONLY && eth_port[0] && !eth_broadcast) begin
            // Straight to the last sync byte
            cmd_only <= 1'b1;
            state    <= ST_SYNC0;
          end
        end
        ST_RUNSTOP: begin
          runstop_we   <= 1'b1;
          runstop_byte <= eth_data;
        end
        // Ignore padding until the packet ends
        ST_DISCOVERY: state <= ST_DISCOVERY;
        ST_ENDPOINT: begin
          if (eth_data == 8'h02) state <= ST_SEQ3;
        end
        ST_SEQ3: state <= ST_SEQ2;
        ST_SEQ2: state <= ST_SEQ1;
        ST_SEQ1: begin
          ds_pkt_cnt <= ~ds_pkt_cnt;
          state      <= ST_SEQ0;
        end
        ST_SEQ0: begin
          frame_cnt <= 1'b0;
          if (seq_diff != '0 && !seq_diff[3]) begin
            seq_ref <= eth_data[3:0];
            push_en <= 1'b1;
          end else begin
            push_en <= relax;
          end
          state <= ST_SYNC2;
        end
        ST_SYNC2: begin
          sample_cnt <= '0;
          if (eth_data == SYNC_BYTE) state <= ST_SYNC1;
        end
        ST_SYNC1: begin
          sample_cnt <= '0;
          if (eth_data == SYNC_BYTE) state <= ST_SYNC0;
        end
        ST_SYNC0: begin
          sample_cnt <= '0;
          if (&eth_data[7:2]) state <= ST_CMDCTRL;
        end
        ST_CMDCTRL: begin
          cmd_resprqst <= eth_data[7];
          cmd_addr     <= eth_data[6:1];
          ptt          <= eth_data[0];
          state        <= ST_CMDDATA3;
        end
        ST_CMDDATA3: begin
          cmd_data[31:24] <= eth_data;
          state           <= ST_CMDDATA2;
        end
        ST_CMDDATA2: begin
          cmd_data[23:16] <= eth_data;
          state           <= ST_CMDDATA1;
        end
        ST_CMDDATA1: begin
          cmd_data[15:8] <= eth_data;
          state          <= ST_CMDDATA0;
        end
        ST_CMDDATA0: begin
          cmd_data[7:0] <= eth_data;
          cmd_we        <= 1'b1;
          state         <= cmd_only ? ST_START : ST_PUSHI1;
        end
        ST_PUSHI1: begin
          iq_hold[23:16] <= eth_data;
          state          <= ST_PUSHI0;
        end
        ST_PUSHI0: begin
          iq_hold[15:8] <= eth_data;
          state         <= ST_PUSHQ1;
        end
        ST_PUSHQ1: begin
          iq_hold[7:0] <= eth_data;
          state        <= ST_PUSHQ0;
        end
        ST_PUSHQ0: begin
          sample_we <= push_en && ptt;
          sample_in <= {iq_hold, eth_data};
          if (sample_cnt == CNT_W'(FRAME_SAMPLES - 1)) begin
            // Second frame follows the first, then the packet is done
            if (!frame_cnt) begin
              frame_cnt <= 1'b1;
              state     <= ST_SYNC2;
            end
          end else begin
            sample_cnt <= sample_cnt + 1'b1;
            state      <= ST_PUSHI1;
          end
        end
        default: state <= ST_START;
      endcase
    end
  end

endmodule

//--- hdl/run_watchdog.sv
// Run and wide-spectrum flags with watchdog disable and timeout counter
`timescale 1ns/1ps

module run_watchdog import hpsdr_pkg::*; #(
  parameter int WDOG_BITS = 12
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  runstop_we,
  input  byte_t runstop_byte,
  input  logic  pkt_seen,
  input  logic  watchdog_up,
  input  logic  eth_unreachable,
  output logic  run,
  output logic  wide_spectrum,
  output logic  abort
);

  logic                 wdog_dis;
  logic [WDOG_BITS-1:0] wdog_cnt;

  // Timeout or lost link stops the radio
  assign abort = eth_unreachable || (&wdog_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
      wdog_dis      <= 1'b0;
    end else if (abort) begin
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (runstop_we) begin
      run           <= runstop_byte[0];
      wide_spectrum <= runstop_byte[1];
      wdog_dis      <= runstop_byte[7];
    end
  end

  // Counts only while running without data packets
  always_ff @(posedge clk) begin
    if (rst || !run || wdog_dis || pkt_seen || abort) begin
      wdog_cnt <= '0;
    end else if (watchdog_up) begin
      wdog_cnt <= wdog_cnt + 1'b1;
    end
  end

endmodule

//--- hdl/iq_sample_fifo.sv
// Transmit I/Q sample FIFO with show-ahead ready/valid output and drop counter
`timescale 1ns/1ps

module iq_sample_fifo import hpsdr_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        sample_we,
  input  iq_sample_t  sample_in,
  input  logic        sample_ready,
  output logic        sample_valid,
  output iq_sample_t  sample_data,
  output logic [15:0] drop_cnt
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  iq_sample_t    mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          push;
  logic          pop;

  assign full         = (count == CW'(FIFO_DEPTH));
  assign sample_valid = (count != '0);
  assign sample_data  = mem[rd_ptr];
  assign push         = sample_we && !full;
  assign pop          = sample_valid && sample_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= sample_in;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      drop_cnt <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // No room, sample is lost
      if (sample_we && full) drop_cnt <= drop_cnt + 1'b1;
    end
  end

endmodule

//--- hdl/cmd_regfile.sv
// Command word store with Wishbone classic read port and response request counter
`timescale 1ns/1ps

module cmd_regfile import hpsdr_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_we,
  input  cmd_addr_t  cmd_addr,
  input  cmd_word_t  cmd_data,
  input  logic       cmd_resprqst,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  cmd_addr_t  wb_adr,
  output cmd_word_t  wb_dat_r,
  output logic       wb_ack,
  output logic [7:0] resp_cnt
);

  localparam int NUM_REGS = 2 ** $bits(cmd_addr_t);

  cmd_word_t regs [NUM_REGS];
  logic      wb_req;

  assign wb_req = wb_cyc && wb_stb;

  // Command words from the unpacker, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (cmd_we) begin
      regs[cmd_addr] <= cmd_data;
    end
  end

  // Commands asking the card for a reply
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_cnt <= '0;
    end else if (cmd_we && cmd_resprqst) begin
      resp_cnt <= resp_cnt + 1'b1;
    end
  end

  // Single-cycle ack, one cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req && !wb_ack;
    end
  end

  // Host writes get an ack but change nothing
  always_ff @(posedge clk) begin
    if (wb_req && !wb_we) begin
      wb_dat_r <= regs[wb_adr];
    end
  end

endmodule

//--- hdl/ds_hpsdr_top.sv
// Downstream HPSDR top level with unpacker, watchdog, command store and sample FIFO
`timescale 1ns/1ps

module ds_hpsdr_top import hpsdr_pkg::*; #(
  parameter int FRAME_SAMPLES = 63,
  parameter int FIFO_DEPTH    = 16,
  parameter int WDOG_BITS     = 12
) (
  input  logic        clk,
  input  logic        rst,
  input  port_t       eth_port,
  input  logic        eth_broadcast,
  input  logic        eth_valid,
  input  byte_t       eth_data,
  input  logic        eth_unreachable,
  input  logic        watchdog_up,
  output logic        ptt,
  output logic        run,
  output logic        wide_spectrum,
  output logic        discover_cnt,
  output logic        discover_port,
  output logic        ds_pkt_cnt,
  output logic        sample_valid,
  output iq_sample_t  sample_data,
  input  logic        sample_ready,
  output logic [15:0] drop_cnt,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  cmd_addr_t   wb_adr,
  output cmd_word_t   wb_dat_r,
  output logic        wb_ack,
  output logic [7:0]  resp_cnt
);

  logic       cmd_we;
  cmd_addr_t  cmd_addr;
  cmd_word_t  cmd_data;
  logic       cmd_resprqst;
  logic       runstop_we;
  byte_t      runstop_byte;
  logic       pkt_seen;
  logic       abort;
  logic       sample_we;
  iq_sample_t sample_in;

  ds_unpack #(
    .FRAME_SAMPLES(FRAME_SAMPLES)
  ) i_ds_unpack (
    .clk            (clk),
    .rst            (rst),
    .eth_port       (eth_port),
    .eth_broadcast  (eth_broadcast),
    .eth_valid      (eth_valid),
    .eth_data       (eth_data),
    .eth_unreachable(eth_unreachable),
    .abort          (abort),
    .cmd_we         (cmd_we),
    .cmd_addr       (cmd_addr),
    .cmd_data       (cmd_data),
    .cmd_resprqst   (cmd_resprqst),
    .ptt            (ptt),
    .runstop_we     (runstop_we),
    .runstop_byte   (runstop_byte),
    .pkt_seen       (pkt_seen),
    .ds_pkt_cnt     (ds_pkt_cnt),
    .discover_cnt   (discover_cnt),
    .discover_port  (discover_port),
    .sample_we      (sample_we),
    .sample_in      (sample_in)
  );

  run_watchdog #(
    .WDOG_BITS(WDOG_BITS)
  ) i_run_watchdog (
    .clk            (clk),
    .rst            (rst),
    .runstop_we     (runstop_we),
    .runstop_byte   (runstop_byte),
    .pkt_seen       (pkt_seen),
    .watchdog_up    (watchdog_up),
    .eth_unreachable(eth_unreachable),
    .run            (run),
    .wide_spectrum  (wide_spectrum),
    .abort          (abort)
  );

  iq_sample_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_iq_sample_fifo (
    .clk         (clk),
    .rst         (rst),
    .sample_we   (sample_we),
    .sample_in   (sample_in),
    .sample_ready(sample_ready),
    .sample_valid(sample_valid),
    .sample_data (sample_data),
    .drop_cnt    (drop_cnt)
  );

  cmd_regfile i_cmd_regfile (
    .clk         (clk),
    .rst         (rst),
    .cmd_we      (cmd_we),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .cmd_resprqst(cmd_resprqst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .resp_cnt    (resp_cnt)
  );

endmodule

//--- test/ds_hpsdr_checker.sv
// Bound assertions on Wishbone ack width and sample FIFO output behavior
`timescale 1ns/1ps

module ds_hpsdr_checker import hpsdr_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       wb_ack,
  input logic       sample_valid,
  input logic       sample_ready,
  input iq_sample_t sample_data
);

  int assert_errors = 0;

  // Ack lasts a single cycle
  a_ack_one_cycle: assert property (
    @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
  ) else begin
    assert_errors++;
    $error("wb_ack stayed high for two consecutive cycles");
  end

  a_valid_after_reset: assert property (
    @(posedge clk) rst |=> !sample_valid
  ) else begin
    assert_errors++;
    $error("sample_valid high right after reset");
  end

  // Head of the FIFO holds while the consumer stalls
  a_data_stable: assert property (
    @(posedge clk) disable iff (rst) sample_valid && !sample_ready |=> $stable(sample_data)
  ) else begin
    assert_errors++;
    $error("sample_data changed while stalled");
  end

endmodule

bind ds_hpsdr_top ds_hpsdr_checker i_ds_hpsdr_checker (
  .clk         (clk),
  .rst         (rst),
  .wb_ack      (wb_ack),
  .sample_valid(sample_valid),
  .sample_ready(sample_ready),
  .sample_data (sample_data)
);

//--- test/tb_ds_hpsdr.sv
// Directed testbench for the downstream HPSDR top level with packet, compare and timeout logic
`timescale 1ns/1ps

module tb_ds_hpsdr import hpsdr_pkg::*;;

  localparam int FRAME_SAMPLES = 4;
  localparam int FIFO_DEPTH    = 8;
  localparam int DATA_LEN      = 8 + 2 * (8 + 4 * FRAME_SAMPLES);
  // Two command packets, three run/stop, two discovery, six data packets
  localparam int TOTAL_BYTES   = 2 * 9 + 3 * 4 + 2 * 3 + 6 * DATA_LEN;
  localparam int TIMEOUT_NS    = TOTAL_BYTES * 8 + 2000;

  logic        clk;
  logic        rst;
  port_t       eth_port;
  logic        eth_broadcast;
  logic        eth_valid;
  byte_t       eth_data;
  logic        eth_unreachable;
  logic        watchdog_up;
  logic        ptt;
  logic        run;
  logic        wide_spectrum;
  logic        discover_cnt;
  logic        discover_port;
  logic        ds_pkt_cnt;
  logic        sample_valid;
  iq_sample_t  sample_data;
  logic        sample_ready;
  logic [15:0] drop_cnt;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  cmd_addr_t   wb_adr;
  cmd_word_t   wb_dat_r;
  logic        wb_ack;
  logic [7:0]  resp_cnt;

  byte_t      pkt[$];
  iq_sample_t sent[$];
  iq_sample_t got[$];
  int         seed;
  int         errors;
  int         checks;
  logic       exp_disc;
  logic       exp_pkt;

  ds_hpsdr_top #(
    .FRAME_SAMPLES(FRAME_SAMPLES),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .WDOG_BITS    (4)
  ) i_ds_hpsdr_top (.*);

  always #4 clk = ~clk;

  // Record every ready/valid transfer
  always @(negedge clk) begin
    if (!rst && sample_valid && sample_ready)
      got.push_back(sample_data);
  end

  task automatic check_word(input string name, input cmd_word_t exp, input cmd_word_t act);
    checks++;
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_sample(input string name, input iq_sample_t exp, input iq_sample_t act);
    checks++;
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic begin_packet(input byte_t first, input byte_t kind);
    pkt = {};
    pkt.push_back(first);
    pkt.push_back(PREAMBLE_BYTE);
    pkt.push_back(kind);
  endtask

  // Most significant byte first
  task automatic push_word(input logic [31:0] w);
    pkt.push_back(w[31:24]);
    pkt.push_back(w[23:16]);
    pkt.push_back(w[15:8]);
    pkt.push_back(w[7:0]);
  endtask

  task automatic build_cmd(input cmd_addr_t adr, input logic resp, input logic ptt_bit,
                           input cmd_word_t w);
    begin_packet(8'he0, PKT_CMDONLY);
    pkt.push_back(8'hfc);
    pkt.push_back({resp, adr, ptt_bit});
    push_word(w);
  endtask

  task automatic build_data(input byte_t seq, input logic relax, input logic ptt_bit);
    iq_sample_t s;
    begin_packet(relax ? 8'he2 : 8'he0, PKT_DATA);
    pkt.push_back(8'h02);
    push_word({24'h0, seq});
    repeat (2) begin
      pkt.push_back(SYNC_BYTE);
      pkt.push_back(SYNC_BYTE);
      pkt.push_back(8'hfc);
      pkt.push_back({1'b0, 6'd10, ptt_bit});
      push_word(32'h0102_0304);
      repeat (FRAME_SAMPLES) begin
        s = $random(seed);
        sent.push_back(s);
        push_word(s);
      end
    end
  endtask

  task automatic send_packet(input port_t port);
    foreach (pkt[i]) begin
      @(posedge clk);
      eth_port  <= port;
      eth_valid <= 1'b1;
      eth_data  <= pkt[i];
    end
    @(posedge clk);
    eth_valid <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic wb_read(input cmd_addr_t adr, output cmd_word_t data);
    int cycles;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!wb_ack && cycles < 10);
    if (!wb_ack) begin
      $display("Wishbone read of address %0d got no ack", adr);
      errors++;
    end
    data = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int cycles;
    cycles = 0;
    while (got.size() < n && cycles < 40) begin
      @(posedge clk);
      cycles++;
    end
    if (got.size() < n) begin
      $display("Timed out waiting for %0d samples, only %0d arrived", n, got.size());
      errors++;
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic compare_samples(input string name);
    wait_samples(sent.size());
    check_count(name, sent.size(), got.size());
    for (int i = 0; i < sent.size() && i < got.size(); i++)
      check_sample(name, sent[i], got[i]);
    sent = {};
    got  = {};
  endtask

  task automatic test_cmd_only();
    cmd_word_t rd;
    build_cmd(6'd3, 1'b1, 1'b1, 32'ha1b2_c3d4);
    send_packet(16'd1025);
    check_bit("cmd ptt set", 1'b1, ptt);
    build_cmd(6'd40, 1'b0, 1'b0, 32'h0f1e_2d3c);
    send_packet(16'd1025);
    check_bit("cmd ptt clear", 1'b0, ptt);
    // Only the first command asked for a reply
    check_count("cmd resp cnt", 1, resp_cnt);
    wb_read(6'd3, rd);
    check_word("cmd read addr 3", 32'ha1b2_c3d4, rd);
    wb_read(6'd40, rd);
    check_word("cmd read addr 40", 32'h0f1e_2d3c, rd);
    wb_read(6'd7, rd);
    check_word("cmd read unused addr", 32'h0, rd);
  endtask

  task automatic test_runstop_discovery();
    begin_packet(8'he0, PKT_RUNSTOP);
    pkt.push_back(8'h03);
    send_packet(16'd1024);
    check_bit("runstop run", 1'b1, run);
    check_bit("runstop wide", 1'b1, wide_spectrum);
    begin_packet(8'he0, PKT_DISCOVER);
    send_packet(16'd1024);
    exp_disc = ~exp_disc;
    check_bit("discovery cnt 1024", exp_disc, discover_cnt);
    check_bit("discovery port 1024", 1'b0, discover_port);
    send_packet(16'd1025);
    exp_disc = ~exp_disc;
    check_bit("discovery cnt 1025", exp_disc, discover_cnt);
    check_bit("discovery port 1025", 1'b1, discover_port);
  endtask

  task automatic test_data();
    build_data(8'h00, 1'b0, 1'b1);
    send_packet(16'd1024);
    exp_pkt = ~exp_pkt;
    check_bit("data pkt cnt", exp_pkt, ds_pkt_cnt);
    compare_samples("data ptt on");
    build_data(8'h01, 1'b0, 1'b0);
    send_packet(16'd1024);
    exp_pkt = ~exp_pkt;
    check_bit("data pkt cnt ptt off", exp_pkt, ds_pkt_cnt);
    sent = {};
    compare_samples("data ptt off");
  endtask

  task automatic test_sequence();
    build_data(8'h01, 1'b0, 1'b1);
    send_packet(16'd1024);
    exp_pkt = ~exp_pkt;
    check_bit("seq pkt cnt strict", exp_pkt, ds_pkt_cnt);
    sent = {};
    compare_samples("repeated seq strict");
    build_data(8'h01, 1'b1, 1'b1);
    send_packet(16'd1024);
    exp_pkt = ~exp_pkt;
    check_bit("seq pkt cnt relaxed", exp_pkt, ds_pkt_cnt);
    compare_samples("repeated seq relaxed");
  endtask

  task automatic test_backpressure();
    @(posedge clk);
    sample_ready <= 1'b0;
    build_data(8'h02, 1'b0, 1'b1);
    send_packet(16'd1024);
    build_data(8'h03, 1'b0, 1'b1);
    send_packet(16'd1024);
    check_count("fifo drop cnt", 4 * FRAME_SAMPLES - FIFO_DEPTH, drop_cnt);
    check_count("fifo stalled output", 0, got.size());
    check_bit("fifo valid while full", 1'b1, sample_valid);
    // Only the first FIFO_DEPTH samples were stored
    while (sent.size() > FIFO_DEPTH)
      void'(sent.pop_back());
    @(posedge clk);
    sample_ready <= 1'b1;
    compare_samples("fifo drain");
  endtask

  task automatic pulse_watchdog(input int n);
    repeat (n) begin
      @(posedge clk);
      watchdog_up <= 1'b1;
      @(posedge clk);
      watchdog_up <= 1'b0;
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic test_watchdog();
    begin_packet(8'he0, PKT_RUNSTOP);
    pkt.push_back(8'h01);
    send_packet(16'd1024);
    check_bit("watchdog run start", 1'b1, run);
    check_bit("watchdog wide clear", 1'b0, wide_spectrum);
    pulse_watchdog(15);
    check_bit("watchdog timeout run", 1'b0, run);
    begin_packet(8'he0, PKT_RUNSTOP);
    pkt.push_back(8'h81);
    send_packet(16'd1024);
    pulse_watchdog(15);
    check_bit("watchdog disabled run", 1'b1, run);
  endtask

  initial begin
    seed            = 52;
    errors          = 0;
    checks          = 0;
    exp_disc        = 1'b0;
    exp_pkt         = 1'b0;
    clk             = 1'b0;
    rst             = 1'b1;
    eth_port        = 16'd1025;
    eth_broadcast   = 1'b0;
    eth_valid       = 1'b0;
    eth_data        = 8'h00;
    eth_unreachable = 1'b0;
    watchdog_up     = 1'b0;
    sample_ready    = 1'b1;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_cmd_only();
    test_runstop_discovery();
    test_data();
    test_sequence();
    test_backpressure();
    test_watchdog();
    errors += i_ds_hpsdr_top.i_ds_hpsdr_checker.assert_errors;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- ds_hpsdr.f
hdl/hpsdr_pkg.sv
hdl/ds_unpack.sv
hdl/run_watchdog.sv
hdl/iq_sample_fifo.sv
hdl/cmd_regfile.sv
hdl/ds_hpsdr_top.sv
test/ds_hpsdr_checker.sv
test/tb_ds_hpsdr.sv
